// ==== source/icache_pkg.sv ====
package icache_pkg;

    // fetch address seen by the cache
    localparam int ADDR_W = 32;

    // one cache line holds 16 instructions
    localparam int LINE_W = 512;

    // two instructions per fetch for the dual-issue front end
    localparam int FETCH_W = 64;

    // byte offset inside a line, so the set index starts at bit 6
    localparam int OFFSET_W = 6;

    // picks one of the eight pairs in a line
    // taken from address bits 5 to 3
    localparam int FETCH_SEL_W = 3;

    // fixed at two, the single lru bit per set depends on it
    localparam int NUM_WAYS = 2;

    // controller states
    typedef enum logic [1:0] {
        IDLE   = 2'd0,    // waiting for a fetch
        LOOKUP = 2'd1,    // tag compare and hit response
        MISS   = 2'd2,    // line requested from memory
        REFILL = 2'd3     // response from return buffer, line written
    } state_t;

endpackage

// ==== source/icache_tag_array.sv ====
`timescale 1ns/1ps

module icache_tag_array #(
    parameter int INDEX_WIDTH = 6,
    localparam int TAG_W = icache_pkg::ADDR_W - icache_pkg::OFFSET_W - INDEX_WIDTH
) (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic [INDEX_WIDTH-1:0] i_rd_index,
    input  logic [TAG_W-1:0]       i_lookup_tag,
    input  logic                   i_lru_touch,
    input  logic                   i_fill_we,
    input  logic [INDEX_WIDTH-1:0] i_fill_index,
    output logic                   o_hit,
    output logic                   o_hit_way,
    output logic                   o_fill_way
);

    localparam int SETS = 1 << INDEX_WIDTH;

    logic [TAG_W-1:0]       tag_mem [icache_pkg::NUM_WAYS][SETS];
    logic [SETS-1:0]        valid_q [icache_pkg::NUM_WAYS];
    logic [SETS-1:0]        lru_q;       // way to replace next, per set
    logic [INDEX_WIDTH-1:0] rd_index_q;
    logic [icache_pkg::NUM_WAYS-1:0] way_hit;

    // read side registers the index, compare happens the cycle after
    always_ff @(posedge clk) begin
        rd_index_q <= i_rd_index;
        if (i_fill_we) begin
            tag_mem[o_fill_way][i_fill_index] <= i_lookup_tag; // buffered tag of the miss
        end
    end

    always_comb begin
        for (int w = 0; w < icache_pkg::NUM_WAYS; w++) begin
            way_hit[w] = valid_q[w][rd_index_q] &&
                         (tag_mem[w][rd_index_q] == i_lookup_tag);
        end
    end

    assign o_hit      = |way_hit;
    assign o_hit_way  = way_hit[1];             // 0 when way 0 hits
    assign o_fill_way = lru_q[i_fill_index];    // victim comes straight from lru

    // valid and lru bits
    always_ff @(posedge clk) begin
        if (!rstn) begin
            valid_q <= '{default: '0};
            lru_q   <= '0;
        end else if (i_fill_we) begin
            valid_q[o_fill_way][i_fill_index] <= 1'b1;
            lru_q[i_fill_index] <= ~o_fill_way;     // other way goes next
        end else if (i_lru_touch) begin
            // keep the way just used, mark the other one as victim
            lru_q[rd_index_q] <= ~o_hit_way;
        end
    end

endmodule

// ==== source/icache_data_array.sv ====
`timescale 1ns/1ps

module icache_data_array #(
    parameter int INDEX_WIDTH = 6
) (
    input  logic                               clk,
    input  logic [INDEX_WIDTH-1:0]             i_rd_index,
    input  logic [icache_pkg::FETCH_SEL_W-1:0] i_fetch_sel,
    input  logic                               i_hit_way,
    input  logic                               i_fill_we,
    input  logic                               i_fill_way,
    input  logic [INDEX_WIDTH-1:0]             i_fill_index,
    input  logic [icache_pkg::LINE_W-1:0]      i_fill_line,
    output logic [icache_pkg::FETCH_W-1:0]     o_data
);

    localparam int SETS = 1 << INDEX_WIDTH;

    logic [icache_pkg::LINE_W-1:0] rd_line [icache_pkg::NUM_WAYS];
    logic [icache_pkg::LINE_W-1:0] sel_line;

    for (genvar w = 0; w < icache_pkg::NUM_WAYS; w++) begin : g_way
        logic [icache_pkg::LINE_W-1:0] mem [SETS];
        logic [icache_pkg::LINE_W-1:0] rd_q;
        logic                          way_we;

        assign way_we = i_fill_we && (i_fill_way == 1'(w));

        always_ff @(posedge clk) begin
            if (way_we) begin
                mem[i_fill_index] <= i_fill_line;
            end
            // fill and read on the same set at one edge, forward the new line
            if (way_we && (i_fill_index == i_rd_index)) begin
                rd_q <= i_fill_line;
            end else begin
                rd_q <= mem[i_rd_index];
            end
        end

        assign rd_line[w] = rd_q;
    end

    // way first, then the pair inside the line
    assign sel_line = rd_line[i_hit_way];
    assign o_data   = sel_line[i_fetch_sel*icache_pkg::FETCH_W +: icache_pkg::FETCH_W];

endmodule

// ==== source/icache_ctrl.sv ====
`timescale 1ns/1ps

module icache_ctrl #(
    parameter int INDEX_WIDTH = 6,
    localparam int TAG_W = icache_pkg::ADDR_W - icache_pkg::OFFSET_W - INDEX_WIDTH
) (
    input  logic                               clk,
    input  logic                               rstn,
    // pipeline request
    input  logic                               i_req_valid,
    input  logic [icache_pkg::ADDR_W-1:0]      i_req_addr,
    output logic                               o_req_ready,
    // pipeline response
    output logic                               o_resp_valid,
    output logic [icache_pkg::FETCH_W-1:0]     o_resp_data,
    output logic                               o_resp_adef,
    // memory port
    output logic                               o_mem_req,
    output logic [icache_pkg::ADDR_W-1:0]      o_mem_addr,
    input  logic                               i_mem_ready,
    input  logic [icache_pkg::LINE_W-1:0]      i_mem_line,
    // array side
    output logic [INDEX_WIDTH-1:0]             o_rd_index,
    output logic [TAG_W-1:0]                   o_lookup_tag,
    output logic [icache_pkg::FETCH_SEL_W-1:0] o_fetch_sel,
    input  logic                               i_hit,
    input  logic [icache_pkg::FETCH_W-1:0]     i_array_data,
    output logic                               o_lru_touch,
    output logic                               o_fill_we,
    output logic [INDEX_WIDTH-1:0]             o_fill_index,
    output logic [icache_pkg::LINE_W-1:0]      o_fill_line
);

    localparam int INDEX_LSB = icache_pkg::OFFSET_W;
    localparam int TAG_LSB   = icache_pkg::OFFSET_W + INDEX_WIDTH;
    localparam int SEL_LSB   = icache_pkg::OFFSET_W - icache_pkg::FETCH_SEL_W;

    icache_pkg::state_t state_q;
    icache_pkg::state_t state_d;

    logic [icache_pkg::ADDR_W-1:0] req_addr_q;   // request buffer
    logic [icache_pkg::LINE_W-1:0] ret_buf_q;    // return buffer
    logic                          accept;
    logic                          adef;

    assign accept = i_req_valid && o_req_ready;
    assign adef   = |req_addr_q[1:0];            // fetch must be word aligned

    always_ff @(posedge clk) begin
        if (accept) begin
            req_addr_q <= i_req_addr;
        end
        if (o_mem_req && i_mem_ready) begin
            ret_buf_q <= i_mem_line;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state_q <= icache_pkg::IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d      = state_q;
        o_req_ready  = 1'b0;
        o_resp_valid = 1'b0;
        o_mem_req    = 1'b0;
        o_lru_touch  = 1'b0;
        o_fill_we    = 1'b0;
        case (state_q)
            icache_pkg::IDLE: begin
                o_req_ready = 1'b1;
            end
            icache_pkg::LOOKUP: begin
                if (adef || i_hit) begin
                    o_resp_valid = 1'b1;
                    o_req_ready  = 1'b1;
                    o_lru_touch  = !adef;   // a faulting fetch leaves the arrays alone
                end else begin
                    state_d = icache_pkg::MISS;
                end
            end
            icache_pkg::MISS: begin
                o_mem_req = 1'b1;           // held until the line arrives
                if (i_mem_ready) begin
                    state_d = icache_pkg::REFILL;
                end
            end
            icache_pkg::REFILL: begin
                o_resp_valid = 1'b1;
                o_fill_we    = 1'b1;
                o_req_ready  = 1'b1;
            end
            default: begin
                state_d = icache_pkg::IDLE;
            end
        endcase
        // any cycle that can accept picks the next state from the request
        if (o_req_ready) begin
            state_d = i_req_valid ? icache_pkg::LOOKUP : icache_pkg::IDLE;
        end
    end

    // response data
    always_comb begin
        if (state_q == icache_pkg::REFILL) begin
            o_resp_data = ret_buf_q[o_fetch_sel*icache_pkg::FETCH_W +: icache_pkg::FETCH_W];
        end else if (adef) begin
            o_resp_data = '0;
        end else begin
            o_resp_data = i_array_data;
        end
    end

    assign o_resp_adef = (state_q == icache_pkg::LOOKUP) && adef;

    // new index on acceptance, otherwise keep reading the buffered set
    assign o_rd_index   = accept ? i_req_addr[INDEX_LSB +: INDEX_WIDTH]
                                 : req_addr_q[INDEX_LSB +: INDEX_WIDTH];
    assign o_lookup_tag = req_addr_q[TAG_LSB +: TAG_W];
    assign o_fetch_sel  = req_addr_q[SEL_LSB +: icache_pkg::FETCH_SEL_W];

    assign o_mem_addr   = {req_addr_q[icache_pkg::ADDR_W-1:INDEX_LSB],
                           {icache_pkg::OFFSET_W{1'b0}}};   // line aligned
    assign o_fill_index = req_addr_q[INDEX_LSB +: INDEX_WIDTH];
    assign o_fill_line  = ret_buf_q;

endmodule

// ==== source/icache_top.sv ====
`timescale 1ns/1ps

module icache_top #(
    parameter int INDEX_WIDTH = 6
) (
    input  logic                           clk,
    input  logic                           rstn,
    input  logic                           i_req_valid,
    input  logic [icache_pkg::ADDR_W-1:0]  i_req_addr,
    output logic                           o_req_ready,
    output logic                           o_resp_valid,
    output logic [icache_pkg::FETCH_W-1:0] o_resp_data,
    output logic                           o_resp_adef,
    output logic                           o_mem_req,
    output logic [icache_pkg::ADDR_W-1:0]  o_mem_addr,
    input  logic                           i_mem_ready,
    input  logic [icache_pkg::LINE_W-1:0]  i_mem_line
);

    localparam int TAG_W = icache_pkg::ADDR_W - icache_pkg::OFFSET_W - INDEX_WIDTH;

    logic [INDEX_WIDTH-1:0]             rd_index;
    logic [TAG_W-1:0]                   lookup_tag;
    logic [icache_pkg::FETCH_SEL_W-1:0] fetch_sel;
    logic                               hit;
    logic                               hit_way;
    logic [icache_pkg::FETCH_W-1:0]     array_data;
    logic                               lru_touch;
    logic                               fill_we;
    logic                               fill_way;      // victim picked by the tag array
    logic [INDEX_WIDTH-1:0]             fill_index;
    logic [icache_pkg::LINE_W-1:0]      fill_line;

    icache_ctrl #(
        .INDEX_WIDTH (INDEX_WIDTH)
    ) u_ctrl (
        .clk          (clk),
        .rstn         (rstn),
        .i_req_valid  (i_req_valid),
        .i_req_addr   (i_req_addr),
        .o_req_ready  (o_req_ready),
        .o_resp_valid (o_resp_valid),
        .o_resp_data  (o_resp_data),
        .o_resp_adef  (o_resp_adef),
        .o_mem_req    (o_mem_req),
        .o_mem_addr   (o_mem_addr),
        .i_mem_ready  (i_mem_ready),
        .i_mem_line   (i_mem_line),
        .o_rd_index   (rd_index),
        .o_lookup_tag (lookup_tag),
        .o_fetch_sel  (fetch_sel),
        .i_hit        (hit),
        .i_array_data (array_data),
        .o_lru_touch  (lru_touch),
        .o_fill_we    (fill_we),
        .o_fill_index (fill_index),
        .o_fill_line  (fill_line)
    );

    icache_tag_array #(
        .INDEX_WIDTH (INDEX_WIDTH)
    ) u_tag_array (
        .clk          (clk),
        .rstn         (rstn),
        .i_rd_index   (rd_index),
        .i_lookup_tag (lookup_tag),
        .i_lru_touch  (lru_touch),
        .i_fill_we    (fill_we),
        .i_fill_index (fill_index),
        .o_hit        (hit),
        .o_hit_way    (hit_way),
        .o_fill_way   (fill_way)
    );

    icache_data_array #(
        .INDEX_WIDTH (INDEX_WIDTH)
    ) u_data_array (
        .clk          (clk),
        .i_rd_index   (rd_index),
        .i_fetch_sel  (fetch_sel),
        .i_hit_way    (hit_way),
        .i_fill_we    (fill_we),
        .i_fill_way   (fill_way),
        .i_fill_index (fill_index),
        .i_fill_line  (fill_line),
        .o_data       (array_data)
    );

endmodule

// ==== sim/icache_assert.sv ====
`timescale 1ns/1ps

module icache_assert (
    input logic                          clk,
    input logic                          rstn,
    input logic                          i_req_valid,
    input logic                          i_req_ready,
    input logic                          i_resp_valid,
    input logic                          i_mem_req,
    input logic [icache_pkg::ADDR_W-1:0] i_mem_addr,
    input logic                          i_mem_ready
);

    // line request held with a stable address until memory takes it
    a_mem_hold: assert property (
        @(posedge clk) disable iff (!rstn)
        (i_mem_req && !i_mem_ready) |=> (i_mem_req && $stable(i_mem_addr))
    ) else $error("o_mem_req dropped or o_mem_addr moved before i_mem_ready");

    a_resp_mem_excl: assert property (
        @(posedge clk) disable iff (!rstn)
        !(i_resp_valid && i_mem_req)
    ) else $error("o_resp_valid and o_mem_req high in the same cycle");

    // a lookup either answers at once or turns into a line request
    a_hit_resp: assert property (
        @(posedge clk) disable iff (!rstn)
        ($past(i_req_valid && i_req_ready, 2) && !$past(i_resp_valid)) |-> i_mem_req
    ) else $error("no response in the cycle after acceptance and no line request");

endmodule

bind icache_top icache_assert u_assert (
    .clk          (clk),
    .rstn         (rstn),
    .i_req_valid  (i_req_valid),
    .i_req_ready  (o_req_ready),
    .i_resp_valid (o_resp_valid),
    .i_mem_req    (o_mem_req),
    .i_mem_addr   (o_mem_addr),
    .i_mem_ready  (i_mem_ready)
);

// ==== sim/icache_tb.sv ====
`timescale 1ns/1ps

module icache_tb;

    localparam int INDEX_WIDTH  = 6;
    localparam int TIMEOUT      = 200;    // cycles with neither an accept nor a response
    localparam int RANDOM_STALL = 'hff;   // stall column value for a random delay
    localparam logic [31:0] WORD_MARK = 32'h5a5a0000;

    logic                           clk = 1'b0;
    logic                           rstn;
    logic                           i_req_valid;
    logic [icache_pkg::ADDR_W-1:0]  i_req_addr;
    logic                           o_req_ready;
    logic                           o_resp_valid;
    logic [icache_pkg::FETCH_W-1:0] o_resp_data;
    logic                           o_resp_adef;
    logic                           o_mem_req;
    logic [icache_pkg::ADDR_W-1:0]  o_mem_addr;
    logic                           i_mem_ready;
    logic [icache_pkg::LINE_W-1:0]  i_mem_line;

    // one entry per trace line
    logic [31:0] tr_addr [$];
    logic [63:0] tr_data [$];
    int          tr_miss [$];
    int          tr_stall [$];

    int          errors;
    int          checks;
    int          req_idx;      // next trace entry to present
    int          out_idx;      // fetch waiting for its response
    int          resp_count;
    int          lat;
    int          mem_count;    // line transfers for the outstanding fetch
    int          mem_wait;
    int          cur_stall;
    int          idle;
    logic        outstanding;
    logic        timed_out;

    icache_top #(
        .INDEX_WIDTH (INDEX_WIDTH)
    ) i_dut (
        .clk          (clk),
        .rstn         (rstn),
        .i_req_valid  (i_req_valid),
        .i_req_addr   (i_req_addr),
        .o_req_ready  (o_req_ready),
        .o_resp_valid (o_resp_valid),
        .o_resp_data  (o_resp_data),
        .o_resp_adef  (o_resp_adef),
        .o_mem_req    (o_mem_req),
        .o_mem_addr   (o_mem_addr),
        .i_mem_ready  (i_mem_ready),
        .i_mem_line   (i_mem_line)
    );

    always #2 clk = ~clk;

    // memory content at word address w
    function automatic logic [31:0] rule_word(input logic [31:0] w);
        return w ^ WORD_MARK;
    endfunction

    function automatic logic [icache_pkg::LINE_W-1:0] rule_line(input logic [31:0] line_addr);
        logic [icache_pkg::LINE_W-1:0] fill;
        fill = '0;
        for (int k = 0; k < 16; k++) begin
            fill[32*k +: 32] = rule_word((line_addr >> 2) + 32'(k));
        end
        return fill;
    endfunction

    // low instruction sits at the lower address
    function automatic logic [63:0] rule_pair(input logic [31:0] addr);
        logic [31:0] w;
        w = {2'b00, addr[31:3], 1'b0};
        return {rule_word(w + 32'd1), rule_word(w)};
    endfunction

    task automatic report_mismatch(input string where, input string sig,
                                   input logic [63:0] got, input logic [63:0] exp);
        $display("CHECK FAILED %s %s got 0x%h expected 0x%h", where, sig, got, exp);
        errors++;
    endtask

    task automatic read_trace();
        int          fd;
        string       text;
        logic [31:0] addr;
        logic [63:0] data;
        int          miss;
        int          stall;
        fd = $fopen("sim/icache_trace.txt", "r");
        if (fd == 0) begin
            $display("cannot open the trace file sim/icache_trace.txt");
            errors++;
        end else begin
            while (!$feof(fd)) begin
                if ($fgets(text, fd) > 0) begin
                    // comment and blank lines give fewer than four fields
                    if ($sscanf(text, "%h %h %h %h", addr, data, miss, stall) == 4) begin
                        tr_addr.push_back(addr);
                        tr_data.push_back(data);
                        tr_miss.push_back(miss);
                        tr_stall.push_back(stall);
                    end
                end
            end
            $fclose(fd);
            if (tr_addr.size() == 0) begin
                $display("the trace file holds no fetches");
                errors++;
            end
        end
    endtask

    task automatic check_response();
        logic [63:0] exp_data;
        logic        exp_adef;
        string       where;
        where    = $sformatf("fetch %0d", out_idx);
        exp_adef = (tr_addr[out_idx][1:0] != 2'b00);
        exp_data = exp_adef ? 64'd0 : rule_pair(tr_addr[out_idx]);
        checks++;
        if (tr_data[out_idx] !== exp_data) begin
            $display("trace data for fetch %0d is 0x%h but the fill rule gives 0x%h",
                     out_idx, tr_data[out_idx], exp_data);
            errors++;
        end
        if (o_resp_adef !== exp_adef) begin
            report_mismatch(where, "o_resp_adef", 64'(o_resp_adef), 64'(exp_adef));
        end
        if (o_resp_data !== tr_data[out_idx]) begin
            report_mismatch(where, "o_resp_data", o_resp_data, tr_data[out_idx]);
        end
        // hit and refill responses free the request port in the same cycle
        if (!exp_adef && o_req_ready !== 1'b1) begin
            report_mismatch(where, "o_req_ready", 64'(o_req_ready), 64'd1);
        end
        if (mem_count != tr_miss[out_idx]) begin
            $display("fetch %0d caused %0d line transfers, expected %0d",
                     out_idx, mem_count, tr_miss[out_idx]);
            errors++;
        end
        if (tr_miss[out_idx] == 0 && lat != 1) begin
            $display("fetch %0d answered after %0d cycles instead of 1", out_idx, lat);
            errors++;
        end
    endtask

    initial begin
        rstn        = 1'b0;
        i_req_valid = 1'b0;
        i_req_addr  = '0;
        i_mem_ready = 1'b0;
        i_mem_line  = '0;
        errors      = 0;
        checks      = 0;
        req_idx     = 0;
        out_idx     = 0;
        resp_count  = 0;
        lat         = 0;
        mem_count   = 0;
        mem_wait    = 0;
        cur_stall   = 0;
        idle        = 0;
        outstanding = 1'b0;
        timed_out   = 1'b0;
        void'($urandom(32'haa69));

        read_trace();
        repeat (16) @(posedge clk);
        rstn <= 1'b1;
        checks++;
        if (o_req_ready !== 1'b1) begin
            report_mismatch("after reset", "o_req_ready", 64'(o_req_ready), 64'd1);
        end
        if (o_resp_valid !== 1'b0) begin
            report_mismatch("after reset", "o_resp_valid", 64'(o_resp_valid), 64'd0);
        end
        if (o_mem_req !== 1'b0) begin
            report_mismatch("after reset", "o_mem_req", 64'(o_mem_req), 64'd0);
        end
        if (tr_addr.size() > 0) begin
            i_req_valid <= 1'b1;
            i_req_addr  <= tr_addr[0];
        end

        while (resp_count < tr_addr.size() && !timed_out) begin
            @(posedge clk);
            idle++;
            if (outstanding) lat++;

            // memory model, one line per request after the stall
            if (o_mem_req && i_mem_ready) begin
                mem_count++;
                checks++;
                if (o_mem_addr !== {tr_addr[out_idx][31:6], 6'd0}) begin
                    report_mismatch($sformatf("fetch %0d", out_idx), "o_mem_addr",
                                    64'(o_mem_addr), 64'({tr_addr[out_idx][31:6], 6'd0}));
                end
                i_mem_ready <= 1'b0;
                mem_wait = 0;
            end else if (o_mem_req) begin
                if (mem_wait >= cur_stall) begin
                    i_mem_ready <= 1'b1;
                    i_mem_line  <= rule_line(o_mem_addr);
                end else begin
                    mem_wait++;
                end
            end

            if (o_resp_valid) begin
                idle = 0;
                if (!outstanding) begin
                    $display("response arrived with no fetch outstanding");
                    errors++;
                end else begin
                    check_response();
                    resp_count++;
                    outstanding = 1'b0;
                end
            end else if (outstanding && o_req_ready) begin
                // ready must stay low until the response
                report_mismatch($sformatf("fetch %0d", out_idx), "o_req_ready",
                                64'(o_req_ready), 64'd0);
            end

            if (i_req_valid && o_req_ready) begin
                idle        = 0;
                out_idx     = req_idx;
                outstanding = 1'b1;
                lat         = 0;
                mem_count   = 0;
                mem_wait    = 0;
                cur_stall   = (tr_stall[req_idx] == RANDOM_STALL) ?
                              int'($urandom_range(9, 0)) : tr_stall[req_idx];
                req_idx++;
                if (req_idx < tr_addr.size()) begin
                    i_req_addr <= tr_addr[req_idx];   // next fetch right behind
                end else begin
                    i_req_valid <= 1'b0;
                end
            end

            if (idle > TIMEOUT) begin
                $display("timeout: the cache neither accepted nor answered for %0d cycles",
                         TIMEOUT);
                errors++;
                timed_out = 1'b1;
            end
        end

        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== sim/icache_trace.txt ====
# address  expected_data     miss  stall  (all hex)
# stall ff asks for a random memory delay, misaligned fetches expect data 0
00000100 5a5a00415a5a0040 1 02
00000108 5a5a00435a5a0042 0 00
00000110 5a5a00455a5a0044 0 00
00000118 5a5a00475a5a0046 0 00
0000011c 5a5a00475a5a0046 0 00
00000138 5a5a004f5a5a004e 0 00
00000104 5a5a00415a5a0040 0 00
00001200 5a5a04815a5a0480 1 01
00002208 5a5a08835a5a0882 1 00
00002210 5a5a08855a5a0884 0 00
00001218 5a5a04875a5a0486 0 00
00003220 5a5a0c895a5a0c88 1 03
00001200 5a5a04815a5a0480 0 00
00002200 5a5a08815a5a0880 1 00
00001238 5a5a048f5a5a048e 0 00
00000102 0000000000000000 0 00
00005001 0000000000000000 0 00
00000107 0000000000000000 0 00
0000013c 5a5a004f5a5a004e 0 00
00004040 5a5a10115a5a1010 1 ff
00004078 5a5a101f5a5a101e 0 00
00008444 5a5a21115a5a2110 1 ff
0001f7f8 5a5a7dff5a5a7dfe 1 ff
0001f7c0 5a5a7df15a5a7df0 0 00
00008448 5a5a21135a5a2112 0 00
00006040 5a5a18115a5a1810 1 ff

// ==== list.f ====
source/icache_pkg.sv
source/icache_tag_array.sv
source/icache_data_array.sv
source/icache_ctrl.sv
source/icache_top.sv
sim/icache_assert.sv
sim/icache_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the icache testbench with verilator

set -u

cd "$(dirname "$0")" || exit 1

obj_dir=obj_dir
log_file=sim.log

if ! verilator --binary --timing --assert \
        --top-module icache_tb \
        -f list.f \
        --Mdir "$obj_dir" \
        -o icache_sim; then
    echo "verilator build failed"
    exit 1
fi

"./$obj_dir/icache_sim" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"

if [ "$sim_status" -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "No errors" "$log_file"; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed, see $log_file"
    exit 1
fi
